// ==== compile.f ====
+incdir+.
pito_mem_pkg.sv
pito_axil_front.sv
pito_region_decode.sv
pito_sram_port.sv
pito_mem_subsystem.sv
tb_clock_gen.sv
tb_pito_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_pito_mem_subsystem \
  -f compile.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: build or simulation failed"; exit 1; }

// ==== tb_pito_mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pito_mem_defs.svh"

// Behavioral single-cycle SRAM, read data one cycle after req
module sram_model #(
  parameter logic [31:0] FILL_TAG = 32'h0
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire pito_mem_pkg::mem_addr_t addr_i,
  input  wire pito_mem_pkg::bus_strb_t be_i,
  input  wire pito_mem_pkg::bus_data_t wdata_i,
  output pito_mem_pkg::bus_data_t      rdata_o,
  output int                           req_cnt_o,
  output pito_mem_pkg::mem_addr_t      last_addr_o
);

  pito_mem_pkg::bus_data_t mem [0:2047];

  always @(posedge clk_i) begin
    if (reset_i) begin
      // Region tag plus word index
      for (int i = 0; i < 2048; i++) begin
        mem[i] <= FILL_TAG + 32'(i);
      end
      rdata_o     <= '0;
      req_cnt_o   <= 0;
      last_addr_o <= '0;
    end else if (req_i) begin
      req_cnt_o   <= req_cnt_o + 1;
      last_addr_o <= addr_i;
      rdata_o     <= mem[addr_i];
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

module tb_pito_mem_subsystem;

  localparam int          NUM_TESTS = 16;
  localparam int          TIMEOUT   = 50;
  localparam int          REG_IMEM  = 0;
  localparam int          REG_DMEM  = 1;
  localparam int          REG_NONE  = 2;
  localparam logic [31:0] IMEM_FILL = 32'h1000_0000;
  localparam logic [31:0] DMEM_FILL = 32'h2000_0000;

  logic                    clk;
  logic                    reset;
  logic                    awvalid;
  logic                    awready;
  pito_mem_pkg::bus_addr_t awaddr;
  logic                    wvalid;
  logic                    wready;
  pito_mem_pkg::bus_data_t wdata;
  pito_mem_pkg::bus_strb_t wstrb;
  logic                    bvalid;
  logic                    bready;
  pito_mem_pkg::axi_resp_e bresp;
  logic                    arvalid;
  logic                    arready;
  pito_mem_pkg::bus_addr_t araddr;
  logic                    rvalid;
  logic                    rready;
  pito_mem_pkg::bus_data_t rdata;
  pito_mem_pkg::axi_resp_e rresp;
  logic                    imem_req;
  logic                    imem_we;
  pito_mem_pkg::mem_addr_t imem_addr;
  pito_mem_pkg::bus_strb_t imem_be;
  pito_mem_pkg::bus_data_t imem_wdata;
  pito_mem_pkg::bus_data_t imem_rdata;
  int                      imem_req_cnt;
  pito_mem_pkg::mem_addr_t imem_last_addr;
  logic                    dmem_req;
  logic                    dmem_we;
  pito_mem_pkg::mem_addr_t dmem_addr;
  pito_mem_pkg::bus_strb_t dmem_be;
  pito_mem_pkg::bus_data_t dmem_wdata;
  pito_mem_pkg::bus_data_t dmem_rdata;
  int                      dmem_req_cnt;
  pito_mem_pkg::mem_addr_t dmem_last_addr;

  // Reference memories for expected read data
  pito_mem_pkg::bus_data_t ref_imem [0:2047];
  pito_mem_pkg::bus_data_t ref_dmem [0:2047];

  // ==========================================================
  // Stimulus table
  // ==========================================================
  bit                      is_wr_tab    [0:NUM_TESTS-1];
  pito_mem_pkg::bus_addr_t addr_tab     [0:NUM_TESTS-1];
  pito_mem_pkg::bus_data_t wdata_tab    [0:NUM_TESTS-1];
  pito_mem_pkg::bus_strb_t strb_tab     [0:NUM_TESTS-1];
  pito_mem_pkg::bus_data_t exp_data_tab [0:NUM_TESTS-1];
  pito_mem_pkg::axi_resp_e exp_resp_tab [0:NUM_TESTS-1];
  int                      stall_tab    [0:NUM_TESTS-1];
  string                   name_tab     [0:NUM_TESTS-1];
  int                      num_entries;
  integer                  seed;
  int                      error_count;
  int                      check_count;

  tb_clock_gen tb_clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  pito_mem_subsystem pito_mem_subsystem_i (
    .clk_i (clk), .reset_i (reset),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp),
    .imem_req_o (imem_req), .imem_we_o (imem_we), .imem_addr_o (imem_addr),
    .imem_be_o (imem_be), .imem_wdata_o (imem_wdata), .imem_rdata_i (imem_rdata),
    .dmem_req_o (dmem_req), .dmem_we_o (dmem_we), .dmem_addr_o (dmem_addr),
    .dmem_be_o (dmem_be), .dmem_wdata_o (dmem_wdata), .dmem_rdata_i (dmem_rdata)
  );

  sram_model #(.FILL_TAG(IMEM_FILL)) imem_model_i (
    .clk_i (clk), .reset_i (reset), .req_i (imem_req), .we_i (imem_we),
    .addr_i (imem_addr), .be_i (imem_be), .wdata_i (imem_wdata),
    .rdata_o (imem_rdata), .req_cnt_o (imem_req_cnt), .last_addr_o (imem_last_addr)
  );

  sram_model #(.FILL_TAG(DMEM_FILL)) dmem_model_i (
    .clk_i (clk), .reset_i (reset), .req_i (dmem_req), .we_i (dmem_we),
    .addr_i (dmem_addr), .be_i (dmem_be), .wdata_i (dmem_wdata),
    .rdata_o (dmem_rdata), .req_cnt_o (dmem_req_cnt), .last_addr_o (dmem_last_addr)
  );

  function automatic int region_of(input pito_mem_pkg::bus_addr_t addr);
    if (addr >= `PITO_IMEM_BASE && addr < `PITO_IMEM_BASE + `PITO_IMEM_LEN) return REG_IMEM;
    if (addr >= `PITO_DMEM_BASE && addr < `PITO_DMEM_BASE + `PITO_DMEM_LEN) return REG_DMEM;
    return REG_NONE;
  endfunction

  // Word index inside the region, offset divided by four
  function automatic pito_mem_pkg::mem_addr_t word_of(input pito_mem_pkg::bus_addr_t addr);
    logic [31:0] off;
    off = addr - ((region_of(addr) == REG_DMEM) ? `PITO_DMEM_BASE : `PITO_IMEM_BASE);
    return pito_mem_pkg::mem_addr_t'(off / 4);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    error_count++;
  endtask

  // Appends one entry and updates the reference memory
  task automatic add_entry(input bit is_wr, input pito_mem_pkg::bus_addr_t addr,
                           input pito_mem_pkg::bus_strb_t strb, input bit stall,
                           input string name);
    int                      region;
    pito_mem_pkg::mem_addr_t word;
    region = region_of(addr);
    word   = word_of(addr);
    is_wr_tab[num_entries]    = is_wr;
    addr_tab[num_entries]     = addr;
    wdata_tab[num_entries]    = $random(seed);
    strb_tab[num_entries]     = strb;
    stall_tab[num_entries]    = stall ? 2 + int'($unsigned($random(seed)) % 5) : 0;
    name_tab[num_entries]     = name;
    exp_data_tab[num_entries] = '0;
    exp_resp_tab[num_entries] = (region == REG_NONE) ? pito_mem_pkg::DECERR : pito_mem_pkg::OKAY;
    if (is_wr && region == REG_IMEM) begin
      ref_imem[word] = merge_bytes(ref_imem[word], wdata_tab[num_entries], strb);
    end else if (is_wr && region == REG_DMEM) begin
      ref_dmem[word] = merge_bytes(ref_dmem[word], wdata_tab[num_entries], strb);
    end else if (!is_wr && region == REG_IMEM) begin
      exp_data_tab[num_entries] = ref_imem[word];
    end else if (!is_wr && region == REG_DMEM) begin
      exp_data_tab[num_entries] = ref_dmem[word];
    end
    num_entries++;
  endtask

  task automatic build_table();
    add_entry(1'b1, `PITO_IMEM_BASE + 32'h010, 4'hF, 1'b0, "imem_word_wr");
    add_entry(1'b0, `PITO_IMEM_BASE + 32'h010, 4'hF, 1'b0, "imem_word_rd");
    add_entry(1'b1, `PITO_DMEM_BASE + 32'h040, 4'hF, 1'b0, "dmem_full_wr");
    add_entry(1'b1, `PITO_DMEM_BASE + 32'h040, 4'b0101, 1'b0, "dmem_strb_0101");
    add_entry(1'b1, `PITO_DMEM_BASE + 32'h040, 4'b1000, 1'b0, "dmem_strb_1000");
    add_entry(1'b0, `PITO_DMEM_BASE + 32'h040, 4'hF, 1'b0, "dmem_merge_rd");
    add_entry(1'b1, `PITO_IMEM_BASE + 32'h100, 4'hF, 1'b0, "imem_same_off_wr");
    add_entry(1'b1, `PITO_DMEM_BASE + 32'h100, 4'hF, 1'b0, "dmem_same_off_wr");
    add_entry(1'b0, `PITO_IMEM_BASE + 32'h100, 4'hF, 1'b0, "imem_same_off_rd");
    add_entry(1'b0, `PITO_DMEM_BASE + 32'h100, 4'hF, 1'b0, "dmem_same_off_rd");
    add_entry(1'b0, 32'h0000_1000, 4'hF, 1'b0, "unmapped_rd");
    add_entry(1'b1, `PITO_DMEM_BASE + `PITO_DMEM_LEN, 4'hF, 1'b0, "unmapped_wr");
    add_entry(1'b0, `PITO_IMEM_BASE + 32'h1FFC, 4'hF, 1'b0, "imem_last_rd");
    add_entry(1'b1, `PITO_DMEM_BASE + 32'h080, 4'hF, 1'b1, "dmem_wr_stall");
    add_entry(1'b0, `PITO_DMEM_BASE + 32'h080, 4'hF, 1'b1, "dmem_rd_stall");
    add_entry(1'b0, `PITO_IMEM_BASE - 32'h4, 4'hF, 1'b0, "below_imem_rd");
  endtask

  // ==========================================================
  // One transaction from the table
  // ==========================================================
  task automatic run_entry(input int idx);
    bit                      is_wr;
    bit                      seen;
    int                      n;
    int                      latency;
    int                      region;
    int                      imem_cnt0;
    int                      dmem_cnt0;
    string                   name;
    pito_mem_pkg::axi_resp_e got_resp;
    pito_mem_pkg::bus_data_t got_data;
    is_wr     = is_wr_tab[idx];
    name      = name_tab[idx];
    region    = region_of(addr_tab[idx]);
    imem_cnt0 = imem_req_cnt;
    dmem_cnt0 = dmem_req_cnt;
    @(negedge clk);
    if (is_wr) begin
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr_tab[idx];
      wdata   = wdata_tab[idx];
      wstrb   = strb_tab[idx];
    end else begin
      arvalid = 1'b1;
      araddr  = addr_tab[idx];
    end
    bready = (stall_tab[idx] == 0);
    rready = (stall_tab[idx] == 0);
    seen   = 1'b0;
    for (n = 0; n < TIMEOUT && !seen; n++) begin
      #1;
      if (is_wr ? (awready && wready) : arready) seen = 1'b1;
      else @(negedge clk);
    end
    if (!seen) report_timeout({name, " request handshake"});
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    // Count cycles from the accepting edge
    seen    = 1'b0;
    latency = 1;
    for (n = 0; n < TIMEOUT && !seen; n++) begin
      #1;
      if (is_wr ? bvalid : rvalid) begin
        seen = 1'b1;
      end else begin
        @(negedge clk);
        latency++;
      end
    end
    if (!seen) report_timeout({name, " response valid"});
    got_resp = is_wr ? bresp : rresp;
    got_data = rdata;
    check_value({name, "_latency"}, 32'd4, 32'(latency));
    // Ready held low while a read is offered
    for (n = 0; n < stall_tab[idx]; n++) begin
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = `PITO_DMEM_BASE;
      #1;
      check_value({name, "_hold_valid"}, 32'd1, 32'(is_wr ? bvalid : rvalid));
      check_value({name, "_hold_resp"}, 32'(got_resp), 32'(is_wr ? bresp : rresp));
      check_value({name, "_hold_rdata"}, got_data, rdata);
      check_value({name, "_hold_arready"}, 32'd0, 32'(arready));
    end
    if (stall_tab[idx] > 0) begin
      @(negedge clk);
      arvalid = 1'b0;
      bready  = 1'b1;
      rready  = 1'b1;
    end
    @(negedge clk);
    #1;
    check_value({name, "_valid_drop"}, 32'd0, 32'(bvalid || rvalid));
    check_value({name, "_resp"}, 32'(exp_resp_tab[idx]), 32'(got_resp));
    if (!is_wr) check_value({name, "_rdata"}, exp_data_tab[idx], got_data);
    check_value({name, "_imem_reqs"}, 32'(region == REG_IMEM), 32'(imem_req_cnt - imem_cnt0));
    check_value({name, "_dmem_reqs"}, 32'(region == REG_DMEM), 32'(dmem_req_cnt - dmem_cnt0));
    if (region == REG_IMEM) begin
      check_value({name, "_imem_addr"}, 32'(word_of(addr_tab[idx])), 32'(imem_last_addr));
    end
    if (region == REG_DMEM) begin
      check_value({name, "_dmem_addr"}, 32'(word_of(addr_tab[idx])), 32'(dmem_last_addr));
    end
  endtask

  initial begin
    seed        = 46164;
    error_count = 0;
    check_count = 0;
    num_entries = 0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    for (int i = 0; i < 2048; i++) begin
      ref_imem[i] = IMEM_FILL + 32'(i);
      ref_dmem[i] = DMEM_FILL + 32'(i);
    end
    build_table();
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      #1;
      if (!reset) break;
    end
    if (reset) report_timeout("reset release");
    // Idle state after reset, nothing offered yet
    check_value("reset_awready", 32'd0, 32'(awready));
    check_value("reset_wready", 32'd0, 32'(wready));
    check_value("reset_arready", 32'd0, 32'(arready));
    check_value("reset_bvalid", 32'd0, 32'(bvalid));
    check_value("reset_rvalid", 32'd0, 32'(rvalid));
    check_value("reset_imem_req", 32'd0, 32'(imem_req));
    check_value("reset_dmem_req", 32'd0, 32'(dmem_req));
    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
    end
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the DUT sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== pito_mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module pito_mem_subsystem (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // AXI4-Lite slave
  input  wire logic                    awvalid_i,
  output logic                         awready_o,
  input  wire pito_mem_pkg::bus_addr_t awaddr_i,
  input  wire logic                    wvalid_i,
  output logic                         wready_o,
  input  wire pito_mem_pkg::bus_data_t wdata_i,
  input  wire pito_mem_pkg::bus_strb_t wstrb_i,
  output logic                         bvalid_o,
  input  wire logic                    bready_i,
  output pito_mem_pkg::axi_resp_e      bresp_o,
  input  wire logic                    arvalid_i,
  output logic                         arready_o,
  input  wire pito_mem_pkg::bus_addr_t araddr_i,
  output logic                         rvalid_o,
  input  wire logic                    rready_i,
  output pito_mem_pkg::bus_data_t      rdata_o,
  output pito_mem_pkg::axi_resp_e      rresp_o,
  // Instruction memory
  output logic                         imem_req_o,
  output logic                         imem_we_o,
  output pito_mem_pkg::mem_addr_t      imem_addr_o,
  output pito_mem_pkg::bus_strb_t      imem_be_o,
  output pito_mem_pkg::bus_data_t      imem_wdata_o,
  input  wire pito_mem_pkg::bus_data_t imem_rdata_i,
  // Data memory
  output logic                         dmem_req_o,
  output logic                         dmem_we_o,
  output pito_mem_pkg::mem_addr_t      dmem_addr_o,
  output pito_mem_pkg::bus_strb_t      dmem_be_o,
  output pito_mem_pkg::bus_data_t      dmem_wdata_o,
  input  wire pito_mem_pkg::bus_data_t dmem_rdata_i
);

  // ==========================================================
  // Stage interconnect
  // ==========================================================

  // Front to decode
  logic                    dec_req;
  logic                    dec_we;
  pito_mem_pkg::bus_addr_t dec_addr;
  pito_mem_pkg::bus_data_t dec_wdata;
  pito_mem_pkg::bus_strb_t dec_strb;
  logic                    dec_done;
  pito_mem_pkg::bus_data_t dec_rdata;
  logic                    dec_err;

  // Decode to SRAM ports
  logic                    imem_start;
  logic                    dmem_start;
  logic                    mem_we;
  pito_mem_pkg::mem_addr_t mem_addr;
  pito_mem_pkg::bus_strb_t mem_be;
  pito_mem_pkg::bus_data_t mem_wdata;
  logic                    imem_done;
  pito_mem_pkg::bus_data_t imem_rdata;
  logic                    dmem_done;
  pito_mem_pkg::bus_data_t dmem_rdata;

  pito_axil_front pito_axil_front_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .req_o     (dec_req),
    .we_o      (dec_we),
    .addr_o    (dec_addr),
    .wdata_o   (dec_wdata),
    .strb_o    (dec_strb),
    .done_i    (dec_done),
    .rdata_i   (dec_rdata),
    .err_i     (dec_err)
  );

  pito_region_decode pito_region_decode_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (dec_req),
    .we_i         (dec_we),
    .addr_i       (dec_addr),
    .wdata_i      (dec_wdata),
    .strb_i       (dec_strb),
    .imem_start_o (imem_start),
    .dmem_start_o (dmem_start),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_be_o     (mem_be),
    .mem_wdata_o  (mem_wdata),
    .imem_done_i  (imem_done),
    .imem_rdata_i (imem_rdata),
    .dmem_done_i  (dmem_done),
    .dmem_rdata_i (dmem_rdata),
    .done_o       (dec_done),
    .rdata_o      (dec_rdata),
    .err_o        (dec_err)
  );

  // Instruction memory port
  pito_sram_port pito_imem_port_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (imem_start),
    .we_i        (mem_we),
    .addr_i      (mem_addr),
    .be_i        (mem_be),
    .wdata_i     (mem_wdata),
    .mem_req_o   (imem_req_o),
    .mem_we_o    (imem_we_o),
    .mem_addr_o  (imem_addr_o),
    .mem_be_o    (imem_be_o),
    .mem_wdata_o (imem_wdata_o),
    .mem_rdata_i (imem_rdata_i),
    .done_o      (imem_done),
    .rdata_o     (imem_rdata)
  );

  // Data memory port
  pito_sram_port pito_dmem_port_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (dmem_start),
    .we_i        (mem_we),
    .addr_i      (mem_addr),
    .be_i        (mem_be),
    .wdata_i     (mem_wdata),
    .mem_req_o   (dmem_req_o),
    .mem_we_o    (dmem_we_o),
    .mem_addr_o  (dmem_addr_o),
    .mem_be_o    (dmem_be_o),
    .mem_wdata_o (dmem_wdata_o),
    .mem_rdata_i (dmem_rdata_i),
    .done_o      (dmem_done),
    .rdata_o     (dmem_rdata)
  );

endmodule

`default_nettype wire

// ==== pito_sram_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module pito_sram_port (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // Request from decode stage
  input  wire logic                    start_i,
  input  wire logic                    we_i,
  input  wire pito_mem_pkg::mem_addr_t addr_i,
  input  wire pito_mem_pkg::bus_strb_t be_i,
  input  wire pito_mem_pkg::bus_data_t wdata_i,
  // Single-cycle SRAM
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output pito_mem_pkg::mem_addr_t      mem_addr_o,
  output pito_mem_pkg::bus_strb_t      mem_be_o,
  output pito_mem_pkg::bus_data_t      mem_wdata_o,
  input  wire pito_mem_pkg::bus_data_t mem_rdata_i,
  // Completion to decode stage
  output logic                         done_o,
  output pito_mem_pkg::bus_data_t      rdata_o
);

  logic outstanding_q;
  logic rd_q;

  // SRAM is always granted, so the request goes out in the start cycle
  assign mem_req_o   = start_i;
  assign mem_we_o    = start_i && we_i;
  assign mem_addr_o  = addr_i;
  assign mem_be_o    = be_i;
  assign mem_wdata_o = wdata_i;

  // Track the request in flight
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 1'b0;
      rd_q          <= 1'b0;
    end else begin
      outstanding_q <= start_i;
      rd_q          <= start_i && !we_i;
    end
  end

  // Read data is valid one cycle after req
  assign done_o  = outstanding_q;
  assign rdata_o = rd_q ? mem_rdata_i : '0;

  a_req_single: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |=> !mem_req_o);

endmodule

`default_nettype wire

// ==== pito_region_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pito_mem_defs.svh"

module pito_region_decode (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // From front stage
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire pito_mem_pkg::bus_addr_t addr_i,
  input  wire pito_mem_pkg::bus_data_t wdata_i,
  input  wire pito_mem_pkg::bus_strb_t strb_i,
  // To SRAM port stages
  output logic                         imem_start_o,
  output logic                         dmem_start_o,
  output logic                         mem_we_o,
  output pito_mem_pkg::mem_addr_t      mem_addr_o,
  output pito_mem_pkg::bus_strb_t      mem_be_o,
  output pito_mem_pkg::bus_data_t      mem_wdata_o,
  // From SRAM port stages
  input  wire logic                    imem_done_i,
  input  wire pito_mem_pkg::bus_data_t imem_rdata_i,
  input  wire logic                    dmem_done_i,
  input  wire pito_mem_pkg::bus_data_t dmem_rdata_i,
  // Back to front stage
  output logic                         done_o,
  output pito_mem_pkg::bus_data_t      rdata_o,
  output logic                         err_o
);

  pito_mem_pkg::bus_addr_t imem_off;
  pito_mem_pkg::bus_addr_t dmem_off;
  pito_mem_pkg::bus_addr_t sel_off;
  logic                    hit_imem;
  logic                    hit_dmem;
  logic                    miss_q;
  logic                    err_q;

  // Region match and offset from base
  assign imem_off = addr_i - `PITO_IMEM_BASE;
  assign dmem_off = addr_i - `PITO_DMEM_BASE;
  assign hit_imem = (addr_i >= `PITO_IMEM_BASE) &&
                    (addr_i < (`PITO_IMEM_BASE + `PITO_IMEM_LEN));
  assign hit_dmem = (addr_i >= `PITO_DMEM_BASE) &&
                    (addr_i < (`PITO_DMEM_BASE + `PITO_DMEM_LEN));
  assign sel_off  = hit_imem ? imem_off : dmem_off;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      imem_start_o <= 1'b0;
      dmem_start_o <= 1'b0;
      miss_q       <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      imem_start_o <= req_i && hit_imem;
      dmem_start_o <= req_i && hit_dmem;
      miss_q       <= req_i && !hit_imem && !hit_dmem;
      // Delay the miss so it lines up with the SRAM done
      err_q        <= miss_q;
    end
  end

  // Shared request payload for both ports
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      mem_we_o    <= we_i;
      mem_addr_o  <= sel_off[`PITO_MEM_AW+1:2];
      mem_be_o    <= strb_i;
      mem_wdata_o <= wdata_i;
    end
  end

  // Return path, zero data on a miss
  assign done_o  = imem_done_i || dmem_done_i || err_q;
  assign err_o   = err_q;
  assign rdata_o = imem_done_i ? imem_rdata_i :
                   dmem_done_i ? dmem_rdata_i : '0;

  a_one_start: assert property (@(posedge clk_i) disable iff (reset_i)
    !(imem_start_o && dmem_start_o));

endmodule

`default_nettype wire

// ==== pito_axil_front.sv ====
`timescale 1ns/10ps
`default_nettype none

module pito_axil_front (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // AXI4-Lite slave
  input  wire logic                    awvalid_i,
  output logic                         awready_o,
  input  wire pito_mem_pkg::bus_addr_t awaddr_i,
  input  wire logic                    wvalid_i,
  output logic                         wready_o,
  input  wire pito_mem_pkg::bus_data_t wdata_i,
  input  wire pito_mem_pkg::bus_strb_t wstrb_i,
  output logic                         bvalid_o,
  input  wire logic                    bready_i,
  output pito_mem_pkg::axi_resp_e      bresp_o,
  input  wire logic                    arvalid_i,
  output logic                         arready_o,
  input  wire pito_mem_pkg::bus_addr_t araddr_i,
  output logic                         rvalid_o,
  input  wire logic                    rready_i,
  output pito_mem_pkg::bus_data_t      rdata_o,
  output pito_mem_pkg::axi_resp_e      rresp_o,
  // Request to decode stage
  output logic                         req_o,
  output logic                         we_o,
  output pito_mem_pkg::bus_addr_t      addr_o,
  output pito_mem_pkg::bus_data_t      wdata_o,
  output pito_mem_pkg::bus_strb_t      strb_o,
  // Completion from decode stage
  input  wire logic                    done_i,
  input  wire pito_mem_pkg::bus_data_t rdata_i,
  input  wire logic                    err_i
);

  pito_mem_pkg::front_state_e state_q;
  logic                       req_q;
  logic                       we_q;
  pito_mem_pkg::bus_addr_t    addr_q;
  pito_mem_pkg::bus_data_t    wdata_q;
  pito_mem_pkg::bus_strb_t    strb_q;
  pito_mem_pkg::bus_data_t    rdata_q;
  pito_mem_pkg::axi_resp_e    resp_q;
  logic                       wr_offer;
  logic                       wr_acc;
  logic                       rd_acc;
  logic                       resp_taken;

  // ==========================================================
  // Handshakes
  // ==========================================================

  // AW and W must both be present, write wins over read
  assign wr_offer   = awvalid_i && wvalid_i;
  assign awready_o  = (state_q == pito_mem_pkg::IDLE) && wr_offer;
  assign wready_o   = awready_o;
  assign arready_o  = (state_q == pito_mem_pkg::IDLE) && arvalid_i && !wr_offer;
  assign wr_acc     = awready_o;
  assign rd_acc     = arready_o;

  assign bvalid_o   = (state_q == pito_mem_pkg::RESP) && we_q;
  assign rvalid_o   = (state_q == pito_mem_pkg::RESP) && !we_q;
  assign resp_taken = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  assign bresp_o    = resp_q;
  assign rresp_o    = resp_q;
  assign rdata_o    = rdata_q;

  // ==========================================================
  // FSM
  // ==========================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= pito_mem_pkg::IDLE;
      req_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      // One-cycle pulse after the accepting edge
      req_q <= wr_acc || rd_acc;
      if (wr_acc) begin
        we_q <= 1'b1;
      end else if (rd_acc) begin
        we_q <= 1'b0;
      end
      case (state_q)
        pito_mem_pkg::IDLE: if (wr_acc || rd_acc) state_q <= pito_mem_pkg::BUSY;
        pito_mem_pkg::BUSY: if (done_i) state_q <= pito_mem_pkg::RESP;
        pito_mem_pkg::RESP: if (resp_taken) state_q <= pito_mem_pkg::IDLE;
        default: state_q <= pito_mem_pkg::IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
    end else if (rd_acc) begin
      addr_q  <= araddr_i;
      strb_q  <= '1;
    end
    if ((state_q == pito_mem_pkg::BUSY) && done_i) begin
      resp_q  <= err_i ? pito_mem_pkg::DECERR : pito_mem_pkg::OKAY;
      rdata_q <= rdata_i;
    end
  end

  assign req_o   = req_q;
  assign we_o    = we_q;
  assign addr_o  = addr_q;
  assign wdata_o = wdata_q;
  assign strb_o  = strb_q;

  // Only one address channel may be ready at a time
  a_one_addr_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    !(awready_o && arready_o));

  // A transaction answers on exactly one response channel
  a_one_resp_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    !(bvalid_o && rvalid_o));

endmodule

`default_nettype wire

// ==== pito_mem_pkg.sv ====
`default_nettype none

`include "pito_mem_defs.svh"

package pito_mem_pkg;

  // Byte address on the AXI-Lite side
  typedef logic [31:0] bus_addr_t;

  // Data word and its byte strobe
  typedef logic [`PITO_DATA_W-1:0]   bus_data_t;
  typedef logic [`PITO_DATA_W/8-1:0] bus_strb_t;

  // Word address on the SRAM side
  typedef logic [`PITO_MEM_AW-1:0] mem_addr_t;

  // AXI response codes in use here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_e;

  // Front stage FSM
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUSY = 2'b01,
    RESP = 2'b10
  } front_state_e;

endpackage

`default_nettype wire

// ==== pito_mem_defs.svh ====
`ifndef PITO_MEM_DEFS_SVH
`define PITO_MEM_DEFS_SVH

// ==========================================================
// Memory map
// ==========================================================

// Instruction memory region, 8 KiB
`define PITO_IMEM_BASE 32'h0020_0000
`define PITO_IMEM_LEN  32'h0000_2000

// Data memory region, 8 KiB, right after imem
`define PITO_DMEM_BASE 32'h0020_2000
`define PITO_DMEM_LEN  32'h0000_2000

// ==========================================================
// Widths
// ==========================================================

// Bus and SRAM data width
`define PITO_DATA_W 32

// Word address into one 2048-word SRAM
`define PITO_MEM_AW 11

`endif
